/* hw/frame_stack.sv */
module frame_stack (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_push,
    input  logic                      i_pop,
    input  gomoku_pkg::search_frame_t i_frame,
    output gomoku_pkg::search_frame_t o_top,
    output logic                      o_empty
);
    import gomoku_pkg::*;

    search_frame_t mem [MAX_DEPTH];
    depth_t        level_r;                 // frames held
    depth_t        top_idx;

    // index of the newest frame, pinned to 0 while empty
    assign top_idx = (level_r == '0) ? '0 : level_r - depth_t'(1);

    assign o_top   = mem[top_idx];
    assign o_empty = (level_r == '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            level_r <= '0;
        end else if (i_push) begin
            level_r <= level_r + depth_t'(1);
        end else if (i_pop && !o_empty) begin
            level_r <= level_r - depth_t'(1);
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_push) begin
            mem[level_r] <= i_frame;    // write above the current top
        end
    end

endmodule

/* hw/gomoku_pkg.sv */
package gomoku_pkg;

    // board geometry
    localparam int BOARD_DIM = 15;
    localparam int N_CELLS   = BOARD_DIM * BOARD_DIM;

    // search limits
    localparam int MAX_DEPTH = 10;                  // stack frames, largest depth limit

    // line evaluation
    localparam int WIN_LEN    = 5;                  // stones in a five
    localparam int SCAN_REACH = WIN_LEN - 1;        // cells looked at on each side
    localparam int LINE_SPAN  = 2 * SCAN_REACH + 1;
    localparam int N_DIRS     = 4;

    // horizontal, vertical, diagonal, anti-diagonal
    localparam int DIR_DR [N_DIRS] = '{0, 1, 1, 1};
    localparam int DIR_DC [N_DIRS] = '{1, 0, 1, -1};

    typedef logic [1:0] cell_t;

    localparam cell_t CELL_EMPTY    = 2'd0;
    localparam cell_t CELL_ATTACKER = 2'd1;
    localparam cell_t CELL_DEFENDER = 2'd2;
    localparam cell_t CELL_BLOCKED  = 2'd3;      // also used for off-board cells

    // row-major, index = row * BOARD_DIM + col
    typedef cell_t [N_CELLS-1:0] board_t;

    typedef logic [7:0] pos_t;
    typedef logic [3:0] depth_t;
    typedef logic [3:0] coord_t;                // row or column

    localparam pos_t LAST_POS = pos_t'(N_CELLS - 1);

    typedef enum logic [1:0] {
        THREAT_NONE = 2'd0,
        THREAT_FOUR = 2'd1,
        THREAT_FIVE = 2'd2
    } threat_kind_t;

    // one level of the depth-first search
    typedef struct packed {
        logic resume_end;                        // nothing left to scan at this level
        pos_t resume;                            // next attacker scan index
        pos_t move;                              // attacker stone
        pos_t reply;                             // forced defender stone
    } search_frame_t;

endpackage

/* hw/threat_scan.sv */
module threat_scan (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_start,
    input  gomoku_pkg::board_t      i_board,
    input  gomoku_pkg::cell_t       i_side,
    input  gomoku_pkg::pos_t        i_from,
    output logic                    o_done,
    output gomoku_pkg::threat_kind_t o_kind,
    output gomoku_pkg::pos_t        o_pos,
    output gomoku_pkg::pos_t        o_block
);
    import gomoku_pkg::*;

    logic         busy_r;
    pos_t         idx_r;
    coord_t       row_r;
    coord_t       col_r;

    cell_t        line [LINE_SPAN];         // cells along one direction, center in the middle
    int           own;
    int           gaps;
    int           gap_k;
    threat_kind_t cell_kind;
    pos_t         cell_block;
    logic         hit;
    logic         last;

    function automatic cell_t cell_at(board_t b, int r, int c);
        if (r < 0 || r >= BOARD_DIM || c < 0 || c >= BOARD_DIM) begin
            return CELL_BLOCKED;
        end
        return b[r * BOARD_DIM + c];
    endfunction

    // evaluate the current cell as if i_side had played there
    always_comb begin
        cell_kind  = THREAT_NONE;
        cell_block = '0;
        own        = 0;
        gaps       = 0;
        gap_k      = 0;
        for (int d = 0; d < N_DIRS; d++) begin
            for (int k = 0; k < LINE_SPAN; k++) begin
                if (k == SCAN_REACH) begin
                    line[k] = i_side;
                end else begin
                    line[k] = cell_at(i_board,
                                      int'(row_r) + (k - SCAN_REACH) * DIR_DR[d],
                                      int'(col_r) + (k - SCAN_REACH) * DIR_DC[d]);
                end
            end
            // every five-cell window that contains the center
            for (int s = SCAN_REACH; s >= 0; s--) begin
                own   = 0;
                gaps  = 0;
                gap_k = 0;
                for (int j = 0; j < WIN_LEN; j++) begin
                    if (line[s + j] == i_side) begin
                        own++;
                    end else if (line[s + j] == CELL_EMPTY) begin
                        gaps++;
                        gap_k = s + j;
                    end
                end
                if (own == WIN_LEN) begin
                    cell_kind = THREAT_FIVE;
                end else if (own == WIN_LEN - 1 && gaps == 1 && cell_kind == THREAT_NONE) begin
                    cell_kind  = THREAT_FOUR;      // first four keeps its gap
                    cell_block = pos_t'((int'(row_r) + (gap_k - SCAN_REACH) * DIR_DR[d])
                                        * BOARD_DIM
                                        + int'(col_r) + (gap_k - SCAN_REACH) * DIR_DC[d]);
                end
            end
        end
    end

    assign hit  = (i_board[idx_r] == CELL_EMPTY) && (cell_kind != THREAT_NONE);
    assign last = (idx_r == LAST_POS);

    assign o_done  = busy_r && (hit || last);
    assign o_kind  = hit ? cell_kind : THREAT_NONE;
    assign o_pos   = idx_r;
    assign o_block = cell_block;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            idx_r  <= '0;
            row_r  <= '0;
            col_r  <= '0;
        end else if (i_start) begin
            busy_r <= 1'b1;
            idx_r  <= i_from;
            row_r  <= coord_t'(i_from / BOARD_DIM);
            col_r  <= coord_t'(i_from % BOARD_DIM);
        end else if (busy_r) begin
            if (hit || last) begin
                busy_r <= 1'b0;
            end else begin
                idx_r <= idx_r + pos_t'(1);
                if (col_r == coord_t'(BOARD_DIM - 1)) begin   // wrap to next row
                    col_r <= '0;
                    row_r <= row_r + coord_t'(1);
                end else begin
                    col_r <= col_r + coord_t'(1);
                end
            end
        end
    end

endmodule

/* hw/vcf_search_ctrl.sv */
module vcf_search_ctrl (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_start,
    input  gomoku_pkg::depth_t        i_depth,
    input  gomoku_pkg::board_t        i_board,
    output logic                      o_scan_start,
    output gomoku_pkg::board_t        o_scan_board,
    output gomoku_pkg::cell_t         o_scan_side,
    output gomoku_pkg::pos_t          o_scan_from,
    input  logic                      i_scan_done,
    input  gomoku_pkg::threat_kind_t  i_scan_kind,
    input  gomoku_pkg::pos_t          i_scan_pos,
    input  gomoku_pkg::pos_t          i_scan_block,
    output logic                      o_push,
    output logic                      o_pop,
    output gomoku_pkg::search_frame_t o_frame,
    input  gomoku_pkg::search_frame_t i_top,
    input  logic                      i_empty,
    output logic                      o_win,
    output gomoku_pkg::pos_t          o_move,
    output logic                      o_finish
);
    import gomoku_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SCAN_ATK,
        S_CHECK_REPLY,
        S_DESCEND,
        S_BACKTRACK,
        S_DONE
    } state_t;

    state_t state_r;
    board_t board_r;                        // working board
    depth_t lim_r;
    depth_t level_r;                        // mirrors the stack level
    pos_t   move_r;
    pos_t   reply_r;
    pos_t   root_r;                         // attacker move of the bottom frame
    logic   scan_start_r;
    cell_t  scan_side_r;
    pos_t   scan_from_r;
    logic   win_r;
    pos_t   win_move_r;
    logic   finish_r;
    depth_t lim_in;

    assign lim_in = (i_depth > depth_t'(MAX_DEPTH)) ? depth_t'(MAX_DEPTH) : i_depth;

    assign o_scan_start = scan_start_r;
    assign o_scan_board = board_r;
    assign o_scan_side  = scan_side_r;
    assign o_scan_from  = scan_from_r;

    assign o_push  = (state_r == S_DESCEND);
    assign o_pop   = (state_r == S_BACKTRACK || state_r == S_DONE) && !i_empty;
    assign o_frame = '{resume_end: (move_r == LAST_POS),
                       resume:     move_r + pos_t'(1),
                       move:       move_r,
                       reply:      reply_r};

    assign o_win    = win_r;
    assign o_move   = win_move_r;
    assign o_finish = finish_r;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r      <= S_IDLE;
            board_r      <= '0;
            lim_r        <= '0;
            level_r      <= '0;
            move_r       <= '0;
            reply_r      <= '0;
            root_r       <= '0;
            scan_start_r <= 1'b0;
            scan_side_r  <= CELL_ATTACKER;
            scan_from_r  <= '0;
            win_r        <= 1'b0;
            win_move_r   <= '0;
            finish_r     <= 1'b0;
        end else begin
            scan_start_r <= 1'b0;
            finish_r     <= 1'b0;
            case (state_r)
                S_IDLE: begin
                    if (i_start) begin
                        board_r <= i_board;
                        lim_r   <= lim_in;
                        level_r <= '0;
                        if (lim_in == '0) begin
                            win_r      <= 1'b0;        // no move allowed at all
                            win_move_r <= '0;
                            state_r    <= S_DONE;
                        end else begin
                            scan_start_r <= 1'b1;
                            scan_side_r  <= CELL_ATTACKER;
                            scan_from_r  <= '0;
                            state_r      <= S_SCAN_ATK;
                        end
                    end
                end
                S_SCAN_ATK: begin
                    if (i_scan_done) begin
                        if (i_scan_kind == THREAT_FIVE) begin
                            win_r      <= 1'b1;
                            win_move_r <= (level_r == '0) ? i_scan_pos : root_r;
                            state_r    <= S_DONE;
                        end else if (i_scan_kind == THREAT_FOUR) begin
                            if (level_r + depth_t'(1) >= lim_r) begin
                                // out of depth, try the next cell at this level
                                if (i_scan_pos == LAST_POS) begin
                                    state_r <= S_BACKTRACK;
                                end else begin
                                    scan_start_r <= 1'b1;
                                    scan_from_r  <= i_scan_pos + pos_t'(1);
                                end
                            end else begin
                                move_r              <= i_scan_pos;
                                reply_r             <= i_scan_block;
                                board_r[i_scan_pos] <= CELL_ATTACKER;
                                scan_start_r        <= 1'b1;
                                scan_side_r         <= CELL_DEFENDER;
                                scan_from_r         <= i_scan_block;
                                state_r             <= S_CHECK_REPLY;
                            end
                        end else begin
                            state_r <= S_BACKTRACK;
                        end
                    end
                end
                S_CHECK_REPLY: begin
                    if (i_scan_done) begin
                        if (i_scan_kind == THREAT_FIVE && i_scan_pos == reply_r) begin
                            board_r[move_r] <= CELL_EMPTY;     // defender wins here
                            scan_side_r     <= CELL_ATTACKER;
                            if (move_r == LAST_POS) begin
                                state_r <= S_BACKTRACK;
                            end else begin
                                scan_start_r <= 1'b1;
                                scan_from_r  <= move_r + pos_t'(1);
                                state_r      <= S_SCAN_ATK;
                            end
                        end else begin
                            board_r[reply_r] <= CELL_DEFENDER;
                            state_r          <= S_DESCEND;
                        end
                    end
                end
                S_DESCEND: begin
                    if (level_r == '0) begin
                        root_r <= move_r;
                    end
                    level_r      <= level_r + depth_t'(1);
                    scan_start_r <= 1'b1;
                    scan_side_r  <= CELL_ATTACKER;
                    scan_from_r  <= '0;
                    state_r      <= S_SCAN_ATK;
                end
                S_BACKTRACK: begin
                    if (i_empty) begin
                        win_r      <= 1'b0;
                        win_move_r <= '0;
                        state_r    <= S_DONE;
                    end else begin
                        board_r[i_top.move]  <= CELL_EMPTY;
                        board_r[i_top.reply] <= CELL_EMPTY;
                        level_r              <= level_r - depth_t'(1);
                        if (!i_top.resume_end) begin   // else pop again next cycle
                            scan_start_r <= 1'b1;
                            scan_side_r  <= CELL_ATTACKER;
                            scan_from_r  <= i_top.resume;
                            state_r      <= S_SCAN_ATK;
                        end
                    end
                end
                S_DONE: begin
                    // drain leftover frames before reporting
                    if (!i_empty) begin
                        level_r <= level_r - depth_t'(1);
                    end else begin
                        finish_r <= 1'b1;
                        state_r  <= S_IDLE;
                    end
                end
                default: state_r <= S_IDLE;
            endcase
        end
    end

endmodule

/* hw/vcf_solver_top.sv */
module vcf_solver_top (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_start,
    input  gomoku_pkg::depth_t i_depth,
    input  gomoku_pkg::board_t i_board,
    output logic               o_win,
    output gomoku_pkg::pos_t   o_move,
    output logic               o_finish
);
    import gomoku_pkg::*;

    // controller <-> scanner
    logic          scan_start;
    board_t        scan_board;
    cell_t         scan_side;
    pos_t          scan_from;
    logic          scan_done;
    threat_kind_t  scan_kind;
    pos_t          scan_pos;
    pos_t          scan_block;

    // controller <-> stack
    logic          push;
    logic          pop;
    search_frame_t frame;
    search_frame_t top;
    logic          empty;

    vcf_search_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_depth      (i_depth),
        .i_board      (i_board),
        .o_scan_start (scan_start),
        .o_scan_board (scan_board),
        .o_scan_side  (scan_side),
        .o_scan_from  (scan_from),
        .i_scan_done  (scan_done),
        .i_scan_kind  (scan_kind),
        .i_scan_pos   (scan_pos),
        .i_scan_block (scan_block),
        .o_push       (push),
        .o_pop        (pop),
        .o_frame      (frame),
        .i_top        (top),
        .i_empty      (empty),
        .o_win        (o_win),
        .o_move       (o_move),
        .o_finish     (o_finish)
    );

    threat_scan u_scan (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_start (scan_start),
        .i_board (scan_board),
        .i_side  (scan_side),
        .i_from  (scan_from),
        .o_done  (scan_done),
        .o_kind  (scan_kind),
        .o_pos   (scan_pos),
        .o_block (scan_block)
    );

    frame_stack u_stack (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_push  (push),
        .i_pop   (pop),
        .i_frame (frame),
        .o_top   (top),
        .o_empty (empty)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the VCF solver testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --assert -f verilog.f --top-module vcf_solver_tb
./obj_dir/Vvcf_solver_tb | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0

/* verification/vcf_solver_chk.sv */
module vcf_solver_chk (
    input  logic               i_clk,
    input  logic               i_rst_n,
    input  logic               i_finish,
    input  logic               i_push,
    input  logic               i_pop,
    input  logic               i_scan_start,
    input  logic               i_scan_done,
    input  gomoku_pkg::depth_t i_level,
    input  gomoku_pkg::depth_t i_lim
);
    timeunit 1ns;
    timeprecision 100ps;
    import gomoku_pkg::*;

    logic scan_busy_r;                      // scan started, done not yet seen

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            scan_busy_r <= 1'b0;
        end else if (i_scan_start) begin
            scan_busy_r <= 1'b1;
        end else if (i_scan_done) begin
            scan_busy_r <= 1'b0;
        end
    end

    a_finish_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_finish |=> !i_finish)
        else $error("finish held high for more than one cycle");

    a_push_pop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_push && i_pop))
        else $error("push and pop strobed together");

    a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_push |-> (i_level < i_lim) && (i_level < depth_t'(MAX_DEPTH)))
        else $error("frame pushed with the stack at the depth limit");

    a_scan_start: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_scan_start |-> !scan_busy_r)
        else $error("scan started while another scan is running");

endmodule

/* verification/vcf_solver_tb.sv */
module vcf_solver_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import gomoku_pkg::*;

    localparam int TIMEOUT_CYCLES = 60000;
    localparam int QUIET_CYCLES   = 400;      // longer than any search here

    logic   i_clk;
    logic   i_rst_n;
    logic   i_start;
    depth_t i_depth;
    board_t i_board;
    logic   o_win;
    pos_t   o_move;
    logic   o_finish;

    int          value_errs;
    int          timeout_errs;
    int          other_errs;
    int          n_cases;
    int          fd;
    logic [15:0] lfsr_r;
    bit          more;

    vcf_solver_top dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_start  (i_start),
        .i_depth  (i_depth),
        .i_board  (i_board),
        .o_win    (o_win),
        .o_move   (o_move),
        .o_finish (o_finish)
    );

    bind vcf_search_ctrl vcf_solver_chk u_chk (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_finish     (o_finish),
        .i_push       (o_push),
        .i_pop        (o_pop),
        .i_scan_start (o_scan_start),
        .i_scan_done  (i_scan_done),
        .i_level      (level_r),
        .i_lim        (lim_r)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic idle_gap();
        int gap;
        gap = 0;
        for (int i = 0; i < 3; i++) begin
            lfsr_r = lfsr_step(lfsr_r);
            gap    = (gap << 1) | int'(lfsr_r[0]);
        end
        repeat (gap) @(negedge i_clk);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_pos(input string name, input pos_t got, input pos_t exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
            value_errs++;
        end
    endtask

    // called on the sample where o_finish was seen high
    task automatic check_finish_width();
        @(negedge i_clk);
        if (o_finish !== 1'b0) begin
            $display("Fail o_finish: got 0x%0h expected 0x0 one cycle after the pulse",
                     o_finish);
            value_errs++;
        end
    endtask

    task automatic wait_finish(output bit seen);
        int cnt;
        seen = 1'b0;
        cnt  = 0;
        while (!seen && cnt < TIMEOUT_CYCLES) begin
            @(negedge i_clk);
            cnt++;
            if (o_finish === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("timeout: no finish pulse within %0d cycles", TIMEOUT_CYCLES);
            timeout_errs++;
        end
    endtask

    task automatic watch_quiet();
        int pulses;
        pulses = 0;
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge i_clk);
            if (o_finish === 1'b1) begin
                pulses++;
            end
        end
        if (pulses != 0) begin
            $display("a start pulsed during a search was not ignored: %0d extra finish",
                     pulses);
            other_errs++;
        end
    endtask

    // next line that is neither blank nor a comment
    task automatic next_line(output string s, output bit ok);
        int n;
        ok = 1'b0;
        while (!ok && !$feof(fd)) begin
            n = $fgets(s, fd);
            if (n > 0 && s.getc(0) != "#" && s.getc(0) != "\n" && s.getc(0) != "\r") begin
                ok = 1'b1;
            end
        end
    endtask

    task automatic run_case(output bit got_case);
        string  line;
        bit     ok;
        bit     seen;
        int     depth;
        int     exp_win;
        int     exp_row;
        int     exp_col;
        int     repulse;
        board_t board;
        byte    ch;
        got_case = 1'b0;
        board    = '0;
        next_line(line, ok);
        if (!ok) begin
            return;                         // end of file
        end
        void'($sscanf(line, "%d", depth));
        for (int r = 0; r < BOARD_DIM; r++) begin
            next_line(line, ok);
            if (!ok || line.len() < BOARD_DIM) begin
                $display("stimulus file ends inside a board or has a short row");
                other_errs++;
                return;
            end
            for (int c = 0; c < BOARD_DIM; c++) begin
                ch = line.getc(c);
                if (ch == "X") begin
                    board[r * BOARD_DIM + c] = CELL_ATTACKER;
                end else if (ch == "O") begin
                    board[r * BOARD_DIM + c] = CELL_DEFENDER;
                end
            end
        end
        next_line(line, ok);
        if (!ok || $sscanf(line, "%d %d %d %d", exp_win, exp_row, exp_col, repulse) != 4) begin
            $display("stimulus file has no result line for case %0d", n_cases);
            other_errs++;
            return;
        end
        got_case = 1'b1;
        n_cases++;

        idle_gap();
        i_depth = depth_t'(depth);
        i_board = board;
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        if (repulse != 0) begin
            repeat (4) @(negedge i_clk);
            i_start = 1'b1;                 // controller is busy by now
            @(negedge i_clk);
            i_start = 1'b0;
        end
        wait_finish(seen);
        if (seen) begin
            check_flag("o_win", o_win, exp_win[0]);
            check_pos("o_move", o_move, pos_t'(exp_row * BOARD_DIM + exp_col));
            check_finish_width();
            if (repulse != 0) begin
                watch_quiet();
                check_flag("o_win", o_win, exp_win[0]);
            end
        end
    endtask

    initial begin
        i_rst_n      = 1'b0;
        i_start      = 1'b0;
        i_depth      = '0;
        i_board      = '0;
        value_errs   = 0;
        timeout_errs = 0;
        other_errs   = 0;
        n_cases      = 0;
        lfsr_r       = 16'd42;
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        @(negedge i_clk);

        // reset values, before any start
        check_flag("o_finish", o_finish, 1'b0);
        check_flag("o_win", o_win, 1'b0);
        check_pos("o_move", o_move, '0);

        fd = $fopen("verification/vcf_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            other_errs++;
        end else begin
            more = 1'b1;
            while (more) begin
                run_case(more);
            end
            $fclose(fd);
            if (n_cases == 0) begin
                $display("no cases found in the stimulus file");
                other_errs++;
            end
        end

        repeat (4) @(negedge i_clk);
        $display("cases=%0d errors: value=%0d timeout=%0d other=%0d",
                 n_cases, value_errs, timeout_errs, other_errs);
        if (value_errs + timeout_errs + other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* verification/vcf_stim.txt */
# each case: depth limit, 15 board rows (. empty, X attacker, O defender),
# then: win row col repulse (repulse 1 pulses a second start while busy)
# four on row 7 from the left edge, five at (7,0)
1
...............
...............
...............
...............
...............
...............
...............
.XXXX..........
...............
...............
...............
...............
...............
...............
...............
1 7 0 0
# two-step line needs depth 2, depth 1 finds nothing
1
...............
...............
...............
...............
...............
.....OXXX......
.........X.....
.........X.....
.........X.....
.........O.....
...............
...............
...............
...............
...............
0 0 0 0
# same board, (4,9) is a dead end, win through (5,9)
2
...............
...............
...............
...............
...............
.....OXXX......
.........X.....
.........X.....
.........X.....
.........O.....
...............
...............
...............
...............
...............
1 5 9 0
# (6,4) forces a defender five at (10,4), win through (10,4)
2
...............
...............
...............
...............
...............
...............
...............
....X..........
....X..........
....X..........
OOOO...........
...............
...............
...............
...............
1 10 4 0
# empty board, second start ignored
3
...............
...............
...............
...............
...............
...............
...............
...............
...............
...............
...............
...............
...............
...............
...............
0 0 0 1

/* verilog.f */
hw/gomoku_pkg.sv
hw/threat_scan.sv
hw/frame_stack.sv
hw/vcf_search_ctrl.sv
hw/vcf_solver_top.sv
verification/vcf_solver_chk.sv
verification/vcf_solver_tb.sv
